//--- tb.f
verilog/lcdPkg.sv
verilog/lcdWaitTimer.sv
verilog/lcdBusCycle.sv
verilog/lcdSequencer.sv
verilog/lcdController.sv
dv/lcdPanelModel.sv
dv/lcdController_sva.sv
dv/lcdTb.sv

//--- run.sh
#!/bin/sh
# Build the LCD controller testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module lcdTb --Mdir obj_dir -o lcdTbSim -f tb.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/lcdTbSim > "$LOG" 2>&1
runStatus=$?
cat "$LOG"
if [ $runStatus -ne 0 ]; then
  echo "simulator exited with status $runStatus"
fi

if grep -q "Simulation PASSED" "$LOG"; then
  exit 0
fi
exit 1

//--- dv/lcdTb.sv
`default_nettype none

module lcdTb
  import lcdPkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int SHORT_BUSY = 20;
  localparam int LONG_BUSY = 400;   // busy test draws up to this
  localparam int POLL_PERIOD = ENABLE_CYCLES + HOLD_CYCLES;
  localparam int XFER_MAX = 2 * SETUP_CYCLES + ENABLE_CYCLES + HOLD_CYCLES
                            + (LONG_BUSY / POLL_PERIOD + 2) * POLL_PERIOD;
  // two power-ups, eight line requests, about 40 transfers
  localparam int TIMEOUT_CYCLES = 2 * (WAIT_POWER_CYCLES + WAIT_FUNC_CYCLES + WAIT_INIT_CYCLES)
                                  + 8 * WAIT_ADDR_CYCLES + 40 * XFER_MAX + 1000;
  localparam logic [7:0] BANNER_EXP [9] = '{
    8'h20, 8'h41, 8'h4C, 8'h50, 8'h48, 8'h41, 8'h42, 8'h45, 8'h54
  };

  logic        clk;
  logic        rst;
  logic [7:0]  lcdDataIn;
  logic        nextLine;
  logic [7:0]  gameChar;
  lcdPins_t    pins;
  logic        ready;
  logic        readDone;
  int unsigned cycle = 0;
  int unsigned doneCount = 0; // readDone pulses seen
  int unsigned busyMax = SHORT_BUSY;
  int unsigned relCycle = 0;  // cycle of the last reset release
  int unsigned base = 0;      // log index at the last reset release
  int          seed;

  lcdController lcdController_inst (
    .clk       (clk),
    .rst       (rst),
    .lcdDataIn (lcdDataIn),
    .nextLine  (nextLine),
    .gameChar  (gameChar),
    .pins      (pins),
    .ready     (ready),
    .readDone  (readDone)
  );

  lcdPanelModel panel (
    .clk       (clk),
    .rst       (rst),
    .pins      (pins),
    .now       (cycle),
    .busyMax   (busyMax),
    .lcdDataIn (lcdDataIn)
  );

  bind lcdController lcdController_sva svaCheck (
    .clk      (clk),
    .rst      (rst),
    .pins     (pins),
    .req      (req),
    .reqValid (reqValid),
    .nextLine (nextLine),
    .ready    (ready),
    .readDone (readDone)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 4 ns period
  end

  task automatic failRun();
    $display("Simulation FAILED");
    $fatal(1, "run stopped at the first failing check");
  endtask

  always @(posedge clk)
  begin
    cycle <= cycle + 1;
    if (readDone)
      doneCount <= doneCount + 1;
    if (cycle >= TIMEOUT_CYCLES)
    begin
      $display("timeout: DUT stalled, no progress within %0d cycles", cycle);
      failRun();
    end
    if (lcdController_inst.svaCheck.failCount != 0)
    begin
      $display("a bound protocol assertion failed");
      failRun();
    end
  end

  task automatic step();
    @(posedge clk);
    #1; // drive and sample just after the edge
  endtask

  task automatic checkEq(string name, logic [31:0] expVal, logic [31:0] gotVal);
    if (expVal !== gotVal)
    begin
      $display("ERROR %s exp %h got %h", name, expVal, gotVal);
      failRun();
    end
  endtask

  task automatic waitLog(int unsigned n);
    while (panel.logCount < n)
      step();
  endtask

  task automatic waitReady();
    while (!ready)
      step();
  endtask

  task automatic checkLog(int unsigned idx, logic rsExp, logic [7:0] byteExp);
    checkEq($sformatf("log[%0d].rs", idx), 32'(rsExp), 32'(panel.logRs[idx]));
    checkEq($sformatf("log[%0d].data", idx), 32'(byteExp), 32'(panel.logByte[idx]));
  endtask

  task automatic applyReset();
    rst = 1'b0;
    nextLine = 1'b0;
    step();
    checkEq("pins.en", 0, 32'(pins.en));
    checkEq("pins.dataOe", 0, 32'(pins.dataOe));
    checkEq("pins.on", 0, 32'(pins.on));
    checkEq("ready", 0, 32'(ready));
    checkEq("readDone", 0, 32'(readDone));
    repeat (4)
      step();
    rst = 1'b1;
    relCycle = cycle;
    base = panel.logCount;
    step();
    checkEq("pins.on", 1, 32'(pins.on)); // display power on
  endtask

  task automatic checkInit();
    int unsigned gap;
    while (!pins.en)
      step();
    gap = cycle - relCycle;
    if (gap < WAIT_POWER_CYCLES)
    begin
      $display("first en pulse came only %0d cycles after reset release", gap);
      failRun();
    end
    waitLog(base + 3);
    checkLog(base, 1'b0, 8'h38);
    checkLog(base + 1, 1'b0, 8'h0E);
    checkLog(base + 2, 1'b0, 8'h06);
    gap = panel.logCycle[base + 1] - panel.logCycle[base];
    if (gap < WAIT_FUNC_CYCLES)
    begin
      $display("display-on write came only %0d cycles after function set", gap);
      failRun();
    end
    gap = panel.logCycle[base + 2] - panel.logCycle[base + 1];
    if (gap < WAIT_INIT_CYCLES)
    begin
      $display("entry-mode write came only %0d cycles after display on", gap);
      failRun();
    end
  endtask

  task automatic checkBanner();
    int i;
    waitLog(base + 12);
    for (i = 0; i < 9; i++)
      checkLog(base + 3 + i, 1'b1, BANNER_EXP[i]);
    waitReady();
    checkEq("logCount", base + 12, panel.logCount);
  endtask

  task automatic sendLine(logic [7:0] ch);
    int unsigned n;
    int unsigned d;
    waitReady();
    n = panel.logCount;
    d = doneCount;
    gameChar = ch;
    nextLine = 1'b1;
    step();
    nextLine = 1'b0;
    checkEq("ready", 0, 32'(ready)); // request taken
    waitLog(n + 2);
    waitReady();
    checkLog(n, 1'b0, 8'hC0);
    checkLog(n + 1, 1'b1, ch);
    checkEq("logCount", n + 2, panel.logCount);
    checkEq("readDoneCount", d + 1, doneCount);
  endtask

  task automatic testPowerUp();
    applyReset();
    checkInit();
  endtask

  task automatic testBanner();
    checkBanner();
  endtask

  task automatic testBusy();
    busyMax = LONG_BUSY;
    sendLine(8'($random(seed)));
    sendLine(8'($random(seed)));
    checkEq("busyWrites", 0, panel.busyWrites);
    busyMax = SHORT_BUSY;
  endtask

  task automatic testNextLine();
    sendLine(8'($random(seed)));
  endtask

  task automatic testResetMidTransfer();
    waitReady();
    gameChar = 8'($random(seed));
    nextLine = 1'b1;
    step();
    nextLine = 1'b0;
    while (!pins.en)
      step();
    repeat (3)
      step();
    checkEq("pins.en", 1, 32'(pins.en)); // inside the poll enable
    applyReset();
    checkInit();
  endtask

  task automatic testIgnoredRequest();
    int i;
    waitLog(base + 6); // banner under way
    checkEq("ready", 0, 32'(ready));
    gameChar = 8'h5A;
    nextLine = 1'b1;
    step();
    nextLine = 1'b0;
    checkBanner();
    repeat (100)
      step();
    checkEq("logCount", base + 12, panel.logCount);
    checkEq("ready", 1, 32'(ready));
    for (i = 0; i < 3; i++)
      sendLine(8'($random(seed)));
  endtask

  initial
  begin
    seed = 97321;
    rst = 1'b0;
    nextLine = 1'b0;
    gameChar = 8'h00;
    testPowerUp();
    testBanner();
    testBusy();
    testNextLine();
    testResetMidTransfer();
    testIgnoredRequest();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/lcdController_sva.sv
`default_nettype none

module lcdController_sva
  import lcdPkg::*;
(
  input logic     clk,
  input logic     rst,
  input lcdPins_t pins,
  input lcdReq_t  req,
  input logic     reqValid,
  input logic     nextLine,
  input logic     ready,
  input logic     readDone
);

  timeunit 1ns;
  timeprecision 100ps;

  int failCount = 0; // read by the testbench monitor

  enBusStable: assert property (@(posedge clk) disable iff (!rst)
    $rose(pins.en) |-> $stable(pins.dataOe))
    else
    begin
      failCount++;
      $error("en rose in the cycle dataOe changed");
    end

  readDoneOneCycle: assert property (@(posedge clk) disable iff (!rst)
    readDone |=> !readDone)
    else
    begin
      failCount++;
      $error("readDone held longer than one cycle");
    end

  // a line-2 address request only follows a nextLine taken while idle
  acceptOnlyReady: assert property (@(posedge clk) disable iff (!rst)
    $rose(reqValid && !req.isData && req.dataByte == CMD_LINE2_ADDR)
      |-> $past(nextLine && ready))
    else
    begin
      failCount++;
      $error("nextLine accepted while ready was low");
    end

endmodule

`default_nettype wire

//--- dv/lcdPanelModel.sv
`default_nettype none

module lcdPanelModel
  import lcdPkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  lcdPins_t    pins,
  input  int unsigned now,
  input  int unsigned busyMax,
  output logic [7:0]  lcdDataIn
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int LOG_DEPTH = 128;

  int          seed = 97321;
  int unsigned busyLeft = 0;   // cycles until the busy flag clears
  logic        enQ = 1'b0;
  logic        rwQ = 1'b0;
  int unsigned logCount = 0;
  int unsigned busyWrites = 0; // writes that hit a busy panel
  logic [7:0]  logByte [LOG_DEPTH];
  logic        logRs [LOG_DEPTH];
  int unsigned logCycle [LOG_DEPTH];

  // bf on bit 7, address counter not modeled
  assign lcdDataIn = {busyLeft != 0, 7'h00};

  always @(posedge clk)
  begin
    enQ <= pins.en;
    rwQ <= pins.rw;
    if (busyLeft != 0)
      busyLeft <= busyLeft - 1;
    // Panel latches a write on the falling edge of en
    if (rst && enQ && !pins.en && !rwQ && logCount < LOG_DEPTH)
    begin
      if (busyLeft != 0)
        busyWrites <= busyWrites + 1;
      logByte[logCount] <= pins.dataOut;
      logRs[logCount] <= pins.rs;
      logCycle[logCount] <= now;
      logCount <= logCount + 1;
      busyLeft <= $unsigned($random(seed)) % (busyMax + 1); // internal op time
    end
  end

endmodule

`default_nettype wire

//--- verilog/lcdController.sv
`default_nettype none

module lcdController
  import lcdPkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic [7:0] lcdDataIn,
  input  logic       nextLine,
  input  logic [7:0] gameChar,
  output lcdPins_t   pins,
  output logic       ready,
  output logic       readDone
);

  lcdReq_t  req;
  logic     reqValid;
  logic     reqReady;
  logic     cycleDone;
  logic     waitStart;
  lcdWait_e waitSel;
  logic     waitDone;

  lcdSequencer sequencer (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .reqValid  (reqValid),
    .reqReady  (reqReady),
    .cycleDone (cycleDone),
    .waitStart (waitStart),
    .waitSel   (waitSel),
    .waitDone  (waitDone),
    .nextLine  (nextLine),
    .gameChar  (gameChar),
    .ready     (ready),
    .readDone  (readDone)
  );

  lcdWaitTimer waitTimer (
    .clk       (clk),
    .rst       (rst),
    .waitStart (waitStart),
    .waitSel   (waitSel),
    .waitDone  (waitDone)
  );

  lcdBusCycle busCycle (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .reqValid  (reqValid),
    .reqReady  (reqReady),
    .cycleDone (cycleDone),
    .lcdDataIn (lcdDataIn),
    .pins      (pins)
  );

endmodule

`default_nettype wire

//--- verilog/lcdSequencer.sv
`default_nettype none

module lcdSequencer
  import lcdPkg::*;
(
  input  logic       clk,
  input  logic       rst,
  output lcdReq_t    req,
  output logic       reqValid,
  input  logic       reqReady,
  input  logic       cycleDone,
  output logic       waitStart,
  output lcdWait_e   waitSel,
  input  logic       waitDone,
  input  logic       nextLine,
  input  logic [7:0] gameChar,
  output logic       ready,
  output logic       readDone
);

  seqState_e  state;
  logic       powerArmed; // power-up wait already started
  logic [3:0] bannerIdx;

  assign ready = (state == sIdle);
  assign readDone = (state == sGameChar) && reqValid && reqReady;

  always_comb
  begin
    req = '0;
    reqValid = 1'b0;
    waitStart = 1'b0;
    waitSel = waitPower;
    case (state)
      sWaitPower:
        waitStart = !powerArmed; // first cycle after reset only
      sFuncSet:
      begin
        req = '{isData: 1'b0, pollBusy: 1'b0, dataByte: CMD_FUNCTION_SET};
        reqValid = 1'b1;
        waitStart = cycleDone;
        waitSel = waitFunc;
      end
      sDispOn:
      begin
        req = '{isData: 1'b0, pollBusy: 1'b0, dataByte: CMD_DISPLAY_ON};
        reqValid = 1'b1;
        waitStart = cycleDone;
        waitSel = waitInit;
      end
      sEntry:
      begin
        req = '{isData: 1'b0, pollBusy: 1'b0, dataByte: CMD_ENTRY_MODE};
        reqValid = 1'b1;
      end
      sBanner:
      begin
        req = '{isData: 1'b1, pollBusy: 1'b1, dataByte: BANNER[bannerIdx]};
        reqValid = 1'b1;
      end
      sLine2:
      begin
        req = '{isData: 1'b0, pollBusy: 1'b1, dataByte: CMD_LINE2_ADDR};
        reqValid = 1'b1;
        waitStart = cycleDone; // address settle time
        waitSel = waitAddr;
      end
      sGameChar:
      begin
        req = '{isData: 1'b1, pollBusy: 1'b1, dataByte: gameChar};
        reqValid = 1'b1;
      end
      default:
      begin
        reqValid = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      state <= sWaitPower;
      powerArmed <= 1'b0;
      bannerIdx <= '0;
    end
    else
    begin
      powerArmed <= 1'b1;
      case (state)
        sWaitPower:
          if (waitDone)
            state <= sFuncSet;
        sFuncSet:
          if (cycleDone)
            state <= sWaitFunc;
        sWaitFunc:
          if (waitDone)
            state <= sDispOn;
        sDispOn:
          if (cycleDone)
            state <= sWaitInit;
        sWaitInit:
          if (waitDone)
            state <= sEntry;
        sEntry:
        begin
          if (cycleDone)
          begin
            state <= sBanner;
            bannerIdx <= '0;
          end
        end
        sBanner:
        begin
          if (cycleDone)
          begin
            if (bannerIdx == 4'(BANNER_LEN - 1))
              state <= sIdle; // banner complete
            else
              bannerIdx <= bannerIdx + 1'b1;
          end
        end
        sIdle:
          if (nextLine)
            state <= sLine2;
        sLine2:
          if (cycleDone)
            state <= sWaitAddr;
        sWaitAddr:
          if (waitDone)
            state <= sGameChar;
        sGameChar:
          if (cycleDone)
            state <= sIdle;
        default: state <= sWaitPower;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/lcdBusCycle.sv
`default_nettype none

module lcdBusCycle
  import lcdPkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  lcdReq_t    req,
  input  logic       reqValid,
  output logic       reqReady,
  output logic       cycleDone,
  input  logic [7:0] lcdDataIn,
  output lcdPins_t   pins
);

  typedef enum logic [2:0] {
    pIdle,
    pPollSetup,
    pPollEn,
    pPollHold,
    pSetup,
    pEnable,
    pHold
  } busPhase_e;

  busPhase_e              phase;
  logic [PHASE_CNT_W-1:0] cnt;
  logic                   busyQ; // busy flag seen in the last poll
  lcdReq_t                reqQ;

  // pin pattern for the setup phase of a write
  function automatic lcdPins_t writePins(lcdReq_t r);
    lcdPins_t p;
    p.rs = r.isData;
    p.rw = 1'b0;
    p.en = 1'b0;
    p.on = 1'b1;
    p.dataOe = 1'b1;
    p.dataOut = r.dataByte;
    return p;
  endfunction

  localparam lcdPins_t POLL_PINS = '{rs: 1'b0, rw: 1'b1, en: 1'b0, on: 1'b1,
                                     dataOe: 1'b0, dataOut: 8'h00};

  assign reqReady = (phase == pIdle);
  assign cycleDone = (phase == pHold) && (cnt == '0); // last hold cycle

  always_ff @(posedge clk)
  begin
    if (reqValid && reqReady)
      reqQ <= req;
  end

  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      phase <= pIdle;
      cnt <= '0;
      busyQ <= 1'b0;
      pins <= '0;
    end
    else
    begin
      pins.on <= 1'b1; // display power, set once out of reset
      if (cnt != '0)
        cnt <= cnt - 1'b1;
      case (phase)
        pIdle:
        begin
          if (reqValid)
          begin
            cnt <= PHASE_CNT_W'(SETUP_CYCLES - 1);
            if (req.pollBusy)
            begin
              phase <= pPollSetup;
              pins <= POLL_PINS; // bus released, read instruction reg
            end
            else
            begin
              phase <= pSetup;
              pins <= writePins(req);
            end
          end
        end
        pPollSetup:
        begin
          if (cnt == '0)
          begin
            phase <= pPollEn;
            pins.en <= 1'b1;
            cnt <= PHASE_CNT_W'(ENABLE_CYCLES - 1);
          end
        end
        pPollEn:
        begin
          if (cnt == '0)
          begin
            busyQ <= lcdDataIn[7]; // bf sampled before en falls
            phase <= pPollHold;
            pins.en <= 1'b0;
            cnt <= PHASE_CNT_W'(HOLD_CYCLES - 1);
          end
        end
        pPollHold:
        begin
          if (cnt == '0)
          begin
            if (busyQ)
            begin
              phase <= pPollEn; // still busy, read again
              pins.en <= 1'b1;
              cnt <= PHASE_CNT_W'(ENABLE_CYCLES - 1);
            end
            else
            begin
              phase <= pSetup;
              pins <= writePins(reqQ);
              cnt <= PHASE_CNT_W'(SETUP_CYCLES - 1);
            end
          end
        end
        pSetup:
        begin
          if (cnt == '0)
          begin
            phase <= pEnable;
            pins.en <= 1'b1;
            cnt <= PHASE_CNT_W'(ENABLE_CYCLES - 1);
          end
        end
        pEnable:
        begin
          if (cnt == '0)
          begin
            phase <= pHold;
            pins.en <= 1'b0; // panel latches on this edge
            cnt <= PHASE_CNT_W'(HOLD_CYCLES - 1);
          end
        end
        pHold:
        begin
          if (cnt == '0)
          begin
            phase <= pIdle;
            pins.dataOe <= 1'b0;
          end
        end
        default: phase <= pIdle;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/lcdWaitTimer.sv
`default_nettype none

module lcdWaitTimer
  import lcdPkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     waitStart,
  input  lcdWait_e waitSel,
  output logic     waitDone
);

  logic [WAIT_CNT_W-1:0] cnt;
  logic [WAIT_CNT_W-1:0] loadVal;
  logic                  active;

  // minus one so waitDone lands exactly N cycles after waitStart
  always_comb
  begin
    case (waitSel)
      waitPower: loadVal = WAIT_CNT_W'(WAIT_POWER_CYCLES - 1);
      waitFunc:  loadVal = WAIT_CNT_W'(WAIT_FUNC_CYCLES - 1);
      waitInit:  loadVal = WAIT_CNT_W'(WAIT_INIT_CYCLES - 1);
      default:   loadVal = WAIT_CNT_W'(WAIT_ADDR_CYCLES - 1);
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      active <= 1'b0;
      cnt <= '0;
    end
    else if (waitStart)
    begin
      active <= 1'b1; // restart also aborts a running wait
      cnt <= loadVal;
    end
    else if (active)
    begin
      if (cnt == '0)
        active <= 1'b0;
      else
        cnt <= cnt - 1'b1;
    end
  end

  assign waitDone = active && (cnt == '0);

endmodule

`default_nettype wire

//--- verilog/lcdPkg.sv
`default_nettype none

package lcdPkg;

  // all delays below count clk cycles
  localparam int CLK_KHZ = 1000;                          // 1 MHz clk
  localparam int WAIT_POWER_CYCLES = 15 * CLK_KHZ;        // 15 ms
  localparam int WAIT_FUNC_CYCLES = 5 * CLK_KHZ;          // 5 ms
  localparam int WAIT_INIT_CYCLES = CLK_KHZ / 10;         // 100 us
  localparam int WAIT_ADDR_CYCLES = (40 * CLK_KHZ) / 1000; // 40 us
  localparam int WAIT_CNT_W = $clog2(WAIT_POWER_CYCLES);  // longest wait sets the width

  localparam int SETUP_CYCLES = 2;   // rs/rw/data valid before en
  localparam int ENABLE_CYCLES = 12; // en high
  localparam int HOLD_CYCLES = 4;    // data held after en falls
  localparam int PHASE_CNT_W = $clog2(ENABLE_CYCLES);

  localparam logic [7:0] CMD_FUNCTION_SET = 8'h38; // 8 bit, 2 lines, 5x8
  localparam logic [7:0] CMD_DISPLAY_ON = 8'h0E;   // display and cursor on
  localparam logic [7:0] CMD_ENTRY_MODE = 8'h06;   // increment, no shift
  localparam logic [7:0] CMD_LINE2_ADDR = 8'hC0;   // DDRAM address 40h

  // element 0 is the first character sent
  localparam int BANNER_LEN = 9;
  localparam logic [BANNER_LEN-1:0][7:0] BANNER = {
    8'h54, 8'h45, 8'h42, 8'h41, 8'h48, 8'h50, 8'h4C, 8'h41, 8'h20
  };

  typedef enum logic [1:0] {
    waitPower,
    waitFunc,
    waitInit,
    waitAddr
  } lcdWait_e;

  typedef struct packed {
    logic       isData;   // drives rs
    logic       pollBusy; // read busy flag before the write
    logic [7:0] dataByte;
  } lcdReq_t;

  typedef struct packed {
    logic       rs;
    logic       rw;
    logic       en;
    logic       on;
    logic       dataOe;
    logic [7:0] dataOut;
  } lcdPins_t;

  typedef enum logic [3:0] {
    sWaitPower, sFuncSet, sWaitFunc, sDispOn, sWaitInit, sEntry,
    sBanner, sIdle, sLine2, sWaitAddr, sGameChar
  } seqState_e;

endpackage

`default_nettype wire
